// File: console_snoop.f
+incdir+.
console_pkg.sv
char_push_if.sv
char_pop_if.sv
write_snoop.sv
line_store.sv
line_drain.sv
console_snoop.sv
tb_console_snoop.sv

// File: Bender.yml
package:
  name: console_snoop

sources:
  - include_dirs:
      - .
    files:
      - console_pkg.sv
      - char_push_if.sv
      - char_pop_if.sv
      - write_snoop.sv
      - line_store.sv
      - line_drain.sv
      - console_snoop.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_console_snoop.sv

// File: tb_console_snoop.sv
// Console capture testbench: directed line, exit code, filter, overflow and random line tests
`timescale 1ns/1ps

`include "console_params.svh"

module tb_console_snoop
  import console_pkg::*;
();

  localparam int    NUM_IDS        = 1 << `CON_ID_W;
  localparam int    TILE           = 1;
  localparam addr_t STDOUT_ADDR    = 32'h5FFF0008;  // Base plus 4 bytes for tile 1
  localparam addr_t TILE0_ADDR     = 32'h5FFF0004;  // Neighbour tile, must be ignored
  localparam int    TIMEOUT_CYCLES = 4000;  // All tests together stay below ~800 cycles
  localparam int    DRAIN_LIMIT    = 300;   // Per-test wait for the stream

  logic     clk;
  logic     rst_i;
  logic     aw_valid_i;
  addr_t    aw_addr_i;
  axi_id_t  aw_id_i;
  logic     w_valid_i;
  char_t    w_data_i;
  logic     char_valid_o;
  char_t    char_o;
  axi_id_t  char_id_o;
  logic     line_end_o;
  logic     exit_valid_o;
  char_t    exit_code_o;
  ovf_cnt_t overflow_cnt_o;

  char_t       exp_char[NUM_IDS][$];  // Expected per ID, write order
  char_t       act_char[NUM_IDS][$];  // Emitted per ID
  logic        act_end [NUM_IDS][$];  // line_end_o seen with each char
  axi_id_t     end_ids[$];            // IDs in line completion order
  int          stream_cnt;            // All emitted chars
  int          checks;
  int          value_errs;
  int          other_errs;
  int          cycle_cnt;
  logic [31:0] rng_state;

  console_snoop #(
    .TILE_IDX (TILE)
  ) DUT (
    .clk            (clk),
    .rst_i          (rst_i),
    .aw_valid_i     (aw_valid_i),
    .aw_addr_i      (aw_addr_i),
    .aw_id_i        (aw_id_i),
    .w_valid_i      (w_valid_i),
    .w_data_i       (w_data_i),
    .char_valid_o   (char_valid_o),
    .char_o         (char_o),
    .char_id_o      (char_id_o),
    .line_end_o     (line_end_o),
    .exit_valid_o   (exit_valid_o),
    .exit_code_o    (exit_code_o),
    .overflow_cnt_o (overflow_cnt_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // Stream monitor, outputs are stable at the edge
  always @(posedge clk) begin
    if (!rst_i && char_valid_o) begin
      act_char[char_id_o].push_back(char_o);
      act_end[char_id_o].push_back(line_end_o);
      if (line_end_o) end_ids.push_back(char_id_o);
      stream_cnt++;
    end else if (!rst_i && line_end_o) begin
      other_errs++;
      $display("line_end_o went high without char_valid_o at %0t", $time);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_char(input char_t got, input char_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_id(input axi_id_t got, input axi_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input ovf_cnt_t got, input ovf_cnt_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_exit(input char_t got, input char_t exp, input string what);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // AW beat, then the paired W beat one cycle later
  task automatic write_byte(input addr_t addr, input axi_id_t id, input char_t data);
    @(posedge clk);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    w_valid_i  <= 1'b0;
    @(posedge clk);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
  endtask

  task automatic stray_data(input char_t data);  // W beat with nothing armed
    @(posedge clk);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  // Stdout write that is expected back on the stream
  task automatic put_char(input axi_id_t id, input char_t c);
    write_byte(STDOUT_ADDR, id, c);
    exp_char[id].push_back(c);
  endtask

  task automatic wait_stream(input string name);
    int waited;
    bit done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
      done = 1'b1;
      for (int id = 0; id < NUM_IDS; id++) begin
        if (act_char[id].size() < exp_char[id].size()) done = 1'b0;
      end
    end
    if (!done) begin
      other_errs++;
      $display("%s: stream stalled, not every expected line came out", name);
    end
    repeat (5) @(posedge clk);  // Let stray extra chars show up
  endtask

  // Per ID, chars in order and line_end_o only on the newline
  task automatic compare_stream(input string name);
    int n;
    for (int id = 0; id < NUM_IDS; id++) begin
      if (act_char[id].size() != exp_char[id].size()) begin
        other_errs++;
        $display("%s: ID %0d emitted %0d characters instead of %0d", name, id,
                 act_char[id].size(), exp_char[id].size());
      end
      n = (act_char[id].size() < exp_char[id].size()) ? act_char[id].size()
                                                       : exp_char[id].size();
      for (int k = 0; k < n; k++) begin
        check_char(act_char[id][k], exp_char[id][k],
                   $sformatf("%s ID %0d char %0d", name, id, k));
        if (exp_char[id][k] == `CON_NEWLINE && !act_end[id][k]) begin
          other_errs++;
          $display("%s: line_end_o missing on the newline of ID %0d", name, id);
        end else if (exp_char[id][k] != `CON_NEWLINE && act_end[id][k]) begin
          other_errs++;
          $display("%s: line_end_o set on a non-newline char of ID %0d", name, id);
        end
      end
      exp_char[id].delete();
      act_char[id].delete();
      act_end[id].delete();
    end
    end_ids.delete();
  endtask

  task automatic check_reset_state();
    if (char_valid_o || line_end_o || exit_valid_o) begin
      other_errs++;
      $display("Output strobes are not low after reset");
    end
    check_count(overflow_cnt_o, 16'd0, "overflow_cnt_o after reset");
  endtask

  task automatic test_single_line();
    put_char(2'd0, 8'h68);  // 'h'
    put_char(2'd0, 8'h69);  // 'i'
    put_char(2'd0, `CON_NEWLINE);
    bus_idle();
    wait_stream("single line");
    if (end_ids.size() != 1) begin
      other_errs++;
      $display("single line: saw %0d line ends instead of 1", end_ids.size());
    end else begin
      check_id(end_ids[0], 2'd0, "single line ID");
    end
    compare_stream("single line");
  endtask

  // ID 2 completes first and must come out first
  task automatic test_interleaved();
    put_char(2'd1, 8'h61);
    put_char(2'd2, 8'h78);
    put_char(2'd1, 8'h62);
    put_char(2'd2, 8'h79);
    put_char(2'd2, `CON_NEWLINE);
    put_char(2'd1, 8'h63);
    put_char(2'd1, `CON_NEWLINE);
    bus_idle();
    wait_stream("interleaved");
    if (end_ids.size() != 2) begin
      other_errs++;
      $display("interleaved: saw %0d line ends instead of 2", end_ids.size());
    end else begin
      check_id(end_ids[0], 2'd2, "first finished line ID");
      check_id(end_ids[1], 2'd1, "second finished line ID");
    end
    compare_stream("interleaved");
  endtask

  task automatic test_exit_code();
    int base;
    int waited;
    base   = stream_cnt;
    waited = 0;
    write_byte(`CON_STDERR_ADDR, 2'd0, 8'h2A);
    bus_idle();
    while (!exit_valid_o && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (!exit_valid_o) begin
      other_errs++;
      $display("exit_valid_o never rose after the stderr write");
    end
    check_exit(exit_code_o, 8'h2A, "exit_code_o");
    repeat (10) @(posedge clk);
    if (stream_cnt != base) begin
      other_errs++;
      $display("stderr write produced stream output");
    end
  endtask

  // Nothing here may reach the stream or the counters
  task automatic test_filtering();
    int       base;
    ovf_cnt_t ovf_before;
    base       = stream_cnt;
    ovf_before = overflow_cnt_o;
    write_byte(TILE0_ADDR, 2'd0, 8'h61);
    write_byte(TILE0_ADDR, 2'd0, `CON_NEWLINE);
    write_byte(32'h5FFF000C, 2'd1, `CON_NEWLINE);  // Tile 2 slot
    write_byte(32'h00001000, 2'd2, `CON_NEWLINE);
    stray_data(`CON_NEWLINE);
    stray_data(8'h55);
    bus_idle();
    repeat (20) @(posedge clk);
    if (stream_cnt != base) begin
      other_errs++;
      $display("filtered writes produced %0d stream characters", stream_cnt - base);
    end
    check_count(overflow_cnt_o, ovf_before, "overflow_cnt_o after filtering");
    check_exit(exit_code_o, 8'h2A, "exit_code_o after filtering");
    if (!exit_valid_o) begin
      other_errs++;
      $display("exit_valid_o dropped without a reset");
    end
  endtask

  // 15 chars fit, newline takes the reserved slot, 5 dropped
  task automatic test_overflow();
    for (int i = 0; i < 20; i++) begin
      if (i < `CON_LINE_DEPTH - 1) put_char(2'd3, char_t'(8'h41 + i));
      else write_byte(STDOUT_ADDR, 2'd3, char_t'(8'h41 + i));
    end
    put_char(2'd3, `CON_NEWLINE);
    bus_idle();
    wait_stream("overflow");
    compare_stream("overflow");
    check_count(overflow_cnt_o, 16'd5, "overflow_cnt_o");
  endtask

  task automatic test_random_lines();
    axi_id_t id;
    int      len;
    char_t   c;
    for (int line = 0; line < 12; line++) begin
      rng_state = xorshift32(rng_state);
      id        = axi_id_t'(rng_state[1:0]);
      len       = (rng_state[15:8] % 10) + 1;
      for (int k = 0; k < len; k++) begin
        rng_state = xorshift32(rng_state);
        c         = rng_state[7:0];
        if (c == `CON_NEWLINE) c = 8'h2E;  // Keep newlines at line ends only
        put_char(id, c);
      end
      put_char(id, `CON_NEWLINE);
    end
    bus_idle();
    wait_stream("random lines");
    compare_stream("random lines");
  endtask

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errs,
             other_errs);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    rst_i      = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    stream_cnt = 0;
    checks     = 0;
    value_errs = 0;
    other_errs = 0;
    rng_state  = 32'hc8b158f4;
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    @(posedge clk);
    @(posedge clk);
    check_reset_state();
    test_single_line();
    test_interleaved();
    test_exit_code();
    test_filtering();
    test_overflow();
    test_random_lines();
    $display("Checks: %0d, value errors: %0d, other errors: %0d", checks, value_errs,
             other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: console_snoop.sv
// Console capture top: snooper, per-ID line store and line drain
`timescale 1ns/1ps

module console_snoop
  import console_pkg::*;
#(
  parameter int TILE_IDX = 0  // Tile whose stdout slot is watched
) (
  input  logic     clk,
  input  logic     rst_i,
  // Snooped AXI write strobes
  input  logic     aw_valid_i,
  input  addr_t    aw_addr_i,
  input  axi_id_t  aw_id_i,
  input  logic     w_valid_i,
  input  char_t    w_data_i,
  // Character stream
  output logic     char_valid_o,
  output char_t    char_o,
  output axi_id_t  char_id_o,
  output logic     line_end_o,
  // Exit code and status
  output logic     exit_valid_o,
  output char_t    exit_code_o,
  output ovf_cnt_t overflow_cnt_o
);

  char_push_if push_if ();
  char_pop_if  pop_if ();

  write_snoop #(
    .TILE_IDX (TILE_IDX)
  ) u_write_snoop (
    .clk          (clk),
    .rst_i        (rst_i),
    .aw_valid_i   (aw_valid_i),
    .aw_addr_i    (aw_addr_i),
    .aw_id_i      (aw_id_i),
    .w_valid_i    (w_valid_i),
    .w_data_i     (w_data_i),
    .exit_valid_o (exit_valid_o),
    .exit_code_o  (exit_code_o),
    .push         (push_if.snoop)
  );

  line_store u_line_store (
    .clk            (clk),
    .rst_i          (rst_i),
    .push           (push_if.store),
    .pop            (pop_if.store),
    .overflow_cnt_o (overflow_cnt_o)
  );

  line_drain u_line_drain (
    .clk          (clk),
    .rst_i        (rst_i),
    .pop          (pop_if.drain),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .char_id_o    (char_id_o),
    .line_end_o   (line_end_o)
  );

endmodule

// File: line_drain.sv
// Line drain: picks the lowest ID with a complete line and streams it out
`timescale 1ns/1ps

`include "console_params.svh"

module line_drain
  import console_pkg::*;
(
  input  logic      clk,
  input  logic      rst_i,
  char_pop_if.drain pop,
  output logic      char_valid_o,
  output char_t     char_o,
  output axi_id_t   char_id_o,
  output logic      line_end_o
);

  localparam int NUM_IDS = 1 << `CON_ID_W;

  drain_state_e state_q, state_d;
  axi_id_t      sel_q;    // ID being drained
  axi_id_t      pick_id;  // Lowest ready ID

  // Fixed priority, lowest index wins
  always_comb begin
    pick_id = '0;
    for (int i = NUM_IDS - 1; i >= 0; i--) begin
      if (pop.line_ready[i]) pick_id = axi_id_t'(i);
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      DRAIN_IDLE: if (|pop.line_ready) state_d = DRAIN_PICK;
      DRAIN_PICK: state_d = DRAIN_SEND;
      DRAIN_SEND: if (pop.head_nl) state_d = DRAIN_IDLE;  // Newline is last pop
      default:    state_d = DRAIN_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= DRAIN_IDLE;
      sel_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == DRAIN_PICK) sel_q <= pick_id;  // Held for the whole line
    end
  end

  // One pop per cycle while sending
  assign pop.pop    = (state_q == DRAIN_SEND);
  assign pop.pop_id = sel_q;

  // Output strobe, one cycle behind the pop
  always_ff @(posedge clk) begin
    if (rst_i) begin
      char_valid_o <= 1'b0;
      line_end_o   <= 1'b0;
    end else begin
      char_valid_o <= pop.pop;
      line_end_o   <= pop.pop & pop.head_nl;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (pop.pop) begin
      char_o    <= pop.head_char;
      char_id_o <= sel_q;
    end
  end

endmodule

// File: line_store.sv
// Line store: per-ID character FIFOs with newline counts and overflow counting
`timescale 1ns/1ps

`include "console_params.svh"

module line_store
  import console_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  char_push_if.store push,
  char_pop_if.store  pop,
  output ovf_cnt_t   overflow_cnt_o
);

  localparam int NUM_IDS = 1 << `CON_ID_W;
  localparam int PTR_W   = $clog2(`CON_LINE_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;

  char_t     mem_q  [NUM_IDS][`CON_LINE_DEPTH];  // Character storage
  ptr_t      wptr_q [NUM_IDS];
  ptr_t      rptr_q [NUM_IDS];
  fill_t     fill_q [NUM_IDS];
  line_cnt_t lines_q[NUM_IDS];
  ovf_cnt_t  ovf_q;

  fill_t              fill_cur;     // Occupancy of the pushed ID
  logic               push_ok;      // Push fits
  logic               drop;         // Push rejected
  logic [NUM_IDS-1:0] push_sel;     // Accepted push per ID
  logic [NUM_IDS-1:0] pop_sel;      // Pop per ID
  logic [NUM_IDS-1:0] push_nl_sel;  // Newline stored per ID
  logic [NUM_IDS-1:0] pop_nl_sel;   // Newline removed per ID

  // Wrap for non power of two depths too
  function automatic ptr_t next_ptr(input ptr_t p);
    if (p == ptr_t'(`CON_LINE_DEPTH - 1)) return '0;
    return p + 1'b1;
  endfunction

  // Newline may take the last slot, other chars may not
  assign fill_cur = fill_q[push.push_id];
  assign push_ok  = push.push && (push.push_nl ? (fill_cur < fill_t'(`CON_LINE_DEPTH))
                                               : (fill_cur < fill_t'(`CON_LINE_DEPTH - 1)));
  assign drop     = push.push & ~push_ok;

  always_comb begin
    for (int i = 0; i < NUM_IDS; i++) begin
      push_sel[i]    = push_ok && (push.push_id == axi_id_t'(i));
      pop_sel[i]     = pop.pop && (pop.pop_id == axi_id_t'(i));
      push_nl_sel[i] = push_sel[i] & push.push_nl;
      pop_nl_sel[i]  = pop_sel[i] & pop.head_nl;
      pop.line_ready[i] = (lines_q[i] != '0);
    end
  end

  // Head of the buffer the drain is looking at
  assign pop.head_char = mem_q[pop.pop_id][rptr_q[pop.pop_id]];
  assign pop.head_nl   = (pop.head_char == `CON_NEWLINE);

  always_ff @(posedge clk) begin
    if (push_ok) mem_q[push.push_id][wptr_q[push.push_id]] <= push.push_char;
  end

  // Pointers and counts, push and pop may hit the same ID together
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        wptr_q[i]  <= '0;
        rptr_q[i]  <= '0;
        fill_q[i]  <= '0;
        lines_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        if (push_sel[i]) wptr_q[i] <= next_ptr(wptr_q[i]);
        if (pop_sel[i])  rptr_q[i] <= next_ptr(rptr_q[i]);
        fill_q[i]  <= fill_q[i] + fill_t'(push_sel[i]) - fill_t'(pop_sel[i]);
        lines_q[i] <= lines_q[i] + line_cnt_t'(push_nl_sel[i])
                                 - line_cnt_t'(pop_nl_sel[i]);
      end
    end
  end

  // Dropped characters, saturating
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ovf_q <= '0;
    end else if (drop && (ovf_q != '1)) begin
      ovf_q <= ovf_q + 1'b1;
    end
  end

  assign overflow_cnt_o = ovf_q;

endmodule

// File: write_snoop.sv
// Write snooper: matches console addresses on AW and captures the paired W byte
`timescale 1ns/1ps

`include "console_params.svh"

module write_snoop
  import console_pkg::*;
#(
  parameter int TILE_IDX = 0  // Selects this tile's stdout address
) (
  input  logic         clk,
  input  logic         rst_i,
  input  logic         aw_valid_i,
  input  addr_t        aw_addr_i,
  input  axi_id_t      aw_id_i,
  input  logic         w_valid_i,
  input  char_t        w_data_i,
  output logic         exit_valid_o,
  output char_t        exit_code_o,
  char_push_if.snoop   push
);

  // Per-tile stdout slot, 4 bytes apart
  localparam addr_t STDOUT_ADDR = addr_t'(`CON_STDOUT_BASE + 32'(TILE_IDX) * 32'd4);

  logic    stdout_hit;    // AW matches stdout this cycle
  logic    stderr_hit;    // AW matches stderr this cycle
  logic    stdout_arm_q;  // Waiting for stdout data beat
  logic    stderr_arm_q;  // Waiting for stderr data beat
  logic    stdout_armed;  // Arm seen by this cycle's W
  logic    stderr_armed;
  axi_id_t id_q;          // ID of the pending stdout write
  axi_id_t id_eff;        // ID used by this cycle's W

  assign stdout_hit = aw_valid_i && (aw_addr_i == STDOUT_ADDR);
  assign stderr_hit = aw_valid_i && (aw_addr_i == `CON_STDERR_ADDR);

  // Same-cycle AW and W pair up directly
  assign stdout_armed = stdout_arm_q | stdout_hit;
  assign stderr_armed = stderr_arm_q | stderr_hit;
  assign id_eff       = stdout_hit ? aw_id_i : id_q;  // Newest AW wins

  // Arm flags, any W beat consumes them
  always_ff @(posedge clk) begin
    if (rst_i) begin
      stdout_arm_q <= 1'b0;
      stderr_arm_q <= 1'b0;
    end else begin
      stdout_arm_q <= stdout_armed & ~w_valid_i;
      stderr_arm_q <= stderr_armed & ~w_valid_i;
    end
  end

  // Stored write ID
  always_ff @(posedge clk) begin
    if (stdout_hit) id_q <= aw_id_i;
  end

  // Push strobe and exit flag
  always_ff @(posedge clk) begin
    if (rst_i) begin
      push.push    <= 1'b0;
      exit_valid_o <= 1'b0;
    end else begin
      push.push <= w_valid_i & stdout_armed;
      if (w_valid_i && stderr_armed) exit_valid_o <= 1'b1;  // Sticky until reset
    end
  end

  // Payload, qualified by the strobes above
  always_ff @(posedge clk) begin
    if (w_valid_i && stdout_armed) begin
      push.push_id   <= id_eff;
      push.push_char <= w_data_i;
      push.push_nl   <= (w_data_i == `CON_NEWLINE);  // Decoded once here
    end
    if (w_valid_i && stderr_armed) exit_code_o <= w_data_i;  // Last stderr byte kept
  end

endmodule

// File: char_pop_if.sv
// Character pop channel between the line store and the line drain
`timescale 1ns/1ps

`include "console_params.svh"

interface char_pop_if
  import console_pkg::*;
();

  logic [(1 << `CON_ID_W)-1:0] line_ready;  // Per ID, line count non-zero
  char_t                       head_char;   // Oldest char of pop_id
  logic                        head_nl;     // head_char is a newline

  axi_id_t pop_id;  // Buffer being read
  logic    pop;     // Remove head of pop_id at next edge

  modport store (
    output line_ready,
    output head_char,
    output head_nl,
    input  pop_id,
    input  pop
  );

  modport drain (
    input  line_ready,
    input  head_char,
    input  head_nl,
    output pop_id,
    output pop
  );

endinterface

// File: char_push_if.sv
// Character push channel from the write snooper into the line store
`timescale 1ns/1ps

interface char_push_if
  import console_pkg::*;
();

  logic    push;       // One-cycle strobe, no ready
  axi_id_t push_id;    // Target line buffer
  char_t   push_char;  // Captured byte
  logic    push_nl;    // push_char is a newline

  // Snooper side drives everything
  modport snoop (output push, output push_id, output push_char, output push_nl);

  // Store always accepts, drops when full
  modport store (input push, input push_id, input push_char, input push_nl);

endinterface

// File: console_pkg.sv
// Console capture types: bus vectors, counters and drain FSM states
package console_pkg;

  `include "console_params.svh"

  typedef logic [31:0]          addr_t;     // AXI write address
  typedef logic [`CON_ID_W-1:0] axi_id_t;   // AXI write ID
  typedef logic [7:0]           char_t;     // One console byte

  // Buffer bookkeeping, wide enough for a full buffer of 16
  typedef logic [4:0]  fill_t;      // Occupancy of one ID buffer
  typedef logic [4:0]  line_cnt_t;  // Complete lines waiting
  typedef logic [15:0] ovf_cnt_t;   // Dropped characters, saturating

  // Drain FSM
  typedef enum logic [1:0] {
    DRAIN_IDLE, // Wait for any complete line
    DRAIN_PICK, // Fixed-priority ID choice
    DRAIN_SEND  // Pop one char per cycle up to newline
  } drain_state_e;

endpackage

// File: console_params.svh
// Console capture parameters: ID width, line depth, console addresses
`ifndef CONSOLE_PARAMS_SVH
`define CONSOLE_PARAMS_SVH

// AXI write ID width, one line buffer per ID
`define CON_ID_W 2

// Characters held per ID buffer, one slot kept back for the newline
`define CON_LINE_DEPTH 16

// Shared stderr byte, carries the exit code
`define CON_STDERR_ADDR 32'h5FFF0000

// Tile 0 stdout, each further tile 4 bytes up
`define CON_STDOUT_BASE 32'h5FFF0004

// ASCII line feed
`define CON_NEWLINE 8'd10

`endif
